//--- rtl/shade_pkg.sv
`default_nettype none

package shade_pkg;

    localparam int FRAC_BITS = 16;
    localparam int NUM_LIGHTS = 3;

    // signed Q16.16
    typedef logic signed [31:0] fix_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vec3_t;

    typedef struct packed {
        fix_t r;
        fix_t g;
        fix_t b;
    } rgb_t;

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_RIGHT,
        DIR_DOWN,
        DIR_LEFT
    } dir_t;

    // dir is a unit vector pointing towards the light
    typedef struct packed {
        vec3_t dir;
        rgb_t  intensity;
    } light_t;

    typedef struct packed {
        vec3_t pos;
        dir_t  dir;
    } block_t;

    typedef struct packed {
        vec3_t  ray;
        fix_t   t;
        block_t block;
        rgb_t   mat;
        vec3_t  normal;
    } hit_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [4:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // geometry, Q16.16
    localparam fix_t BLOCK_SIZE = fix_t'(100 * (1 << FRAC_BITS));
    localparam fix_t EDGE_SIZE = fix_t'(20 * (1 << FRAC_BITS));
    // 0.01 rounded down
    localparam fix_t TOP_TOL = fix_t'(655);

    //////////////////////////////////////////////////////////////////////
    // register map, word addresses
    localparam int REG_EYE_X = 0;
    localparam int REG_LIGHT_BASE = 3;
    // dir x, y, z then intensity r, g, b
    localparam int LIGHT_STRIDE = 6;
    localparam int REG_COUNT = REG_LIGHT_BASE + NUM_LIGHTS * LIGHT_STRIDE;

    // pipeline depths in cycles
    localparam int HIT_LATENCY = 2;
    localparam int ARROW_LATENCY = 2;
    localparam int LIGHT_LATENCY = 3;
    localparam int PIXEL_LATENCY = 5;

    // product keeps bits 47:16, overflow wraps
    function automatic fix_t fix_mul(fix_t a, fix_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[FRAC_BITS +: 32];
    endfunction

endpackage

`default_nettype wire

//--- rtl/delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter type T = logic,
    parameter int DEPTH = 2
) (
    input  wire  clk_in,
    input  wire  rst_in,
    input  wire  in_valid,
    input  wire  T in_data,
    output logic out_valid,
    output T     out_data
);

    T data_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    always_ff @(posedge clk_in) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data = data_q[DEPTH-1];

endmodule

`default_nettype wire

//--- rtl/shading_regs.sv
`timescale 1ns/1ps
`default_nettype none

module shading_regs (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire shade_pkg::wb_req_t wb_req,
    output shade_pkg::wb_rsp_t      wb_rsp,
    output shade_pkg::vec3_t        eye,
    output shade_pkg::light_t       lights [shade_pkg::NUM_LIGHTS]
);

    import shade_pkg::*;

    localparam int W = $bits(fix_t);

    vec3_t eye_q;
    light_t lights_q [NUM_LIGHTS];
    logic ack_q;
    logic [31:0] dat_q;
    logic req_seen;
    logic [31:0] words [REG_COUNT];
    logic [31:0] rd_data;

    // ack_q low again before a new request is taken
    assign req_seen = wb_req.cyc && wb_req.stb && !ack_q;

    // flat word view for read-back
    always_comb begin
        words[REG_EYE_X] = eye_q.x;
        words[REG_EYE_X + 1] = eye_q.y;
        words[REG_EYE_X + 2] = eye_q.z;
        for (int l = 0; l < NUM_LIGHTS; l++) begin
            for (int f = 0; f < LIGHT_STRIDE; f++) begin
                words[REG_LIGHT_BASE + l * LIGHT_STRIDE + f] =
                    lights_q[l][(LIGHT_STRIDE - 1 - f) * W +: W];
            end
        end
    end

    assign rd_data = (int'(wb_req.adr) < REG_COUNT) ? words[wb_req.adr] : '0;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ack_q <= 1'b0;
            dat_q <= '0;
            eye_q <= '0;
            for (int l = 0; l < NUM_LIGHTS; l++) begin
                lights_q[l] <= '0;
            end
        end else begin
            ack_q <= req_seen;
            if (req_seen) begin
                dat_q <= rd_data;
                if (wb_req.we) begin
                    case (wb_req.adr)
                        5'(REG_EYE_X):     eye_q.x <= wb_req.dat;
                        5'(REG_EYE_X + 1): eye_q.y <= wb_req.dat;
                        5'(REG_EYE_X + 2): eye_q.z <= wb_req.dat;
                        default: ;
                    endcase
                    for (int l = 0; l < NUM_LIGHTS; l++) begin
                        for (int f = 0; f < LIGHT_STRIDE; f++) begin
                            if (wb_req.adr == 5'(REG_LIGHT_BASE + l * LIGHT_STRIDE + f)) begin
                                lights_q[l][(LIGHT_STRIDE - 1 - f) * W +: W] <= wb_req.dat;
                            end
                        end
                    end
                end
            end
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};
    assign eye = eye_q;
    assign lights = lights_q;

endmodule

`default_nettype wire

//--- rtl/hit_point.sv
`timescale 1ns/1ps
`default_nettype none

module hit_point (
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   in_valid,
    input  wire shade_pkg::vec3_t ray,
    input  wire shade_pkg::fix_t  t,
    input  wire shade_pkg::vec3_t eye,
    output logic                  out_valid,
    output shade_pkg::vec3_t      origin
);

    import shade_pkg::*;

    vec3_t scaled_q;
    logic scaled_valid;

    // stage 1: ray * t
    always_ff @(posedge clk_in) begin
        scaled_q.x <= fix_mul(ray.x, t);
        scaled_q.y <= fix_mul(ray.y, t);
        scaled_q.z <= fix_mul(ray.z, t);
    end

    // stage 2: offset by eye
    always_ff @(posedge clk_in) begin
        origin.x <= eye.x + scaled_q.x;
        origin.y <= eye.y + scaled_q.y;
        origin.z <= eye.z + scaled_q.z;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            scaled_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            scaled_valid <= in_valid;
            out_valid <= scaled_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/arrow_test.sv
`timescale 1ns/1ps
`default_nettype none

module arrow_test (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    in_valid,
    input  wire shade_pkg::vec3_t  origin,
    input  wire shade_pkg::block_t block,
    output logic                   out_valid,
    output logic                   draw
);

    import shade_pkg::*;

    vec3_t rel_q;
    fix_t sum_q;
    fix_t diff_q;
    dir_t dir_q;
    logic rel_valid;

    fix_t abs_x;
    fix_t abs_y;
    logic top_ok;
    logic in_bounds;
    logic region_a;
    logic region_c;
    logic region_ok;

    //////////////////////////////////////////////////////////////////////
    // stage 1: position relative to block centre
    always_ff @(posedge clk_in) begin
        rel_q.x <= origin.x - block.pos.x;
        rel_q.y <= origin.y - block.pos.y;
        rel_q.z <= origin.z - block.pos.z;
        sum_q <= (origin.x - block.pos.x) + (origin.y - block.pos.y);
        diff_q <= (origin.y - block.pos.y) - (origin.x - block.pos.x);
        dir_q <= block.dir;
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: face, bounds and quadrant
    always_comb begin
        abs_x = (rel_q.x < 0) ? -rel_q.x : rel_q.x;
        abs_y = (rel_q.y < 0) ? -rel_q.y : rel_q.y;
        top_ok = (rel_q.z - (BLOCK_SIZE <<< 1)) <= TOP_TOL;
        in_bounds = (abs_x < (BLOCK_SIZE - EDGE_SIZE)) && (abs_y < (BLOCK_SIZE - EDGE_SIZE));
        region_a = sum_q < 0;
        region_c = diff_q < 0;
        region_ok = 1'b0;
        case (dir_q)
            DIR_UP:    region_ok = region_a && region_c;
            DIR_RIGHT: region_ok = !region_a && region_c;
            DIR_DOWN:  region_ok = !region_a && !region_c;
            DIR_LEFT:  region_ok = region_a && !region_c;
            default:   region_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        draw <= top_ok && in_bounds && region_ok;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rel_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rel_valid <= in_valid;
            out_valid <= rel_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/light_term.sv
`timescale 1ns/1ps
`default_nettype none

module light_term (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    in_valid,
    input  wire shade_pkg::vec3_t  normal,
    input  wire shade_pkg::light_t light,
    input  wire shade_pkg::rgb_t   mat,
    output logic                   out_valid,
    output shade_pkg::rgb_t        term
);

    import shade_pkg::*;

    fix_t dot;
    fix_t lambert_q;
    rgb_t lit_q;
    logic lambert_valid;
    logic lit_valid;

    assign dot = fix_mul(light.dir.x, normal.x)
               + fix_mul(light.dir.y, normal.y)
               + fix_mul(light.dir.z, normal.z);

    // surfaces facing away get no light
    always_ff @(posedge clk_in) begin
        lambert_q <= (dot < 0) ? '0 : dot;
    end

    always_ff @(posedge clk_in) begin
        lit_q.r <= fix_mul(lambert_q, light.intensity.r);
        lit_q.g <= fix_mul(lambert_q, light.intensity.g);
        lit_q.b <= fix_mul(lambert_q, light.intensity.b);
    end

    // mat arrives two cycles late to line up here
    always_ff @(posedge clk_in) begin
        term.r <= fix_mul(lit_q.r, mat.r);
        term.g <= fix_mul(lit_q.g, mat.g);
        term.b <= fix_mul(lit_q.b, mat.b);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            lambert_valid <= 1'b0;
            lit_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            lambert_valid <= in_valid;
            lit_valid <= lambert_valid;
            out_valid <= lit_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/color_mix.sv
`timescale 1ns/1ps
`default_nettype none

module color_mix (
    input  wire                  clk_in,
    input  wire                  rst_in,
    input  wire                  in_valid,
    input  wire shade_pkg::rgb_t terms [shade_pkg::NUM_LIGHTS],
    input  wire                  draw,
    output logic                 out_valid,
    output shade_pkg::rgb_t      pixel
);

    import shade_pkg::*;

    rgb_t sum;
    rgb_t sum_q;
    logic sum_valid;
    fix_t peak;

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_LIGHTS; i++) begin
            sum.r += terms[i].r;
            sum.g += terms[i].g;
            sum.b += terms[i].b;
        end
    end

    always_ff @(posedge clk_in) begin
        sum_q <= sum;
    end

    // largest channel, used as arrow grey
    always_comb begin
        peak = sum_q.r;
        if (sum_q.g > peak) begin
            peak = sum_q.g;
        end
        if (sum_q.b > peak) begin
            peak = sum_q.b;
        end
    end

    always_ff @(posedge clk_in) begin
        pixel <= draw ? '{r: peak, g: peak, b: peak} : sum_q;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sum_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            sum_valid <= in_valid;
            out_valid <= sum_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shader (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire shade_pkg::wb_req_t wb_req,
    output shade_pkg::wb_rsp_t      wb_rsp,
    input  wire                     in_valid,
    input  wire shade_pkg::hit_t    hit,
    output logic                    pixel_valid,
    output shade_pkg::rgb_t         pixel
);

    import shade_pkg::*;

    vec3_t eye;
    light_t lights [NUM_LIGHTS];
    vec3_t origin;
    logic origin_valid;
    block_t block_d;
    rgb_t mat_d;
    logic draw;
    rgb_t terms [NUM_LIGHTS];
    logic [NUM_LIGHTS-1:0] term_valid;

    shading_regs shading_regs_i (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .eye    (eye),
        .lights (lights)
    );

    //////////////////////////////////////////////////////////////////////
    // geometry path
    hit_point hit_point_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (in_valid),
        .ray       (hit.ray),
        .t         (hit.t),
        .eye       (eye),
        .out_valid (origin_valid),
        .origin    (origin)
    );

    delay_line #(.T(block_t), .DEPTH(HIT_LATENCY)) block_line_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (in_valid),
        .in_data   (hit.block),
        .out_valid (),
        .out_data  (block_d)
    );

    arrow_test arrow_test_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (origin_valid),
        .origin    (origin),
        .block     (block_d),
        .out_valid (),
        .draw      (draw)
    );

    //////////////////////////////////////////////////////////////////////
    // lighting path
    delay_line #(.T(rgb_t), .DEPTH(LIGHT_LATENCY - 1)) mat_line_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (in_valid),
        .in_data   (hit.mat),
        .out_valid (),
        .out_data  (mat_d)
    );

    for (genvar i = 0; i < NUM_LIGHTS; i++) begin : g_light
        light_term light_term_i (
            .clk_in    (clk_in),
            .rst_in    (rst_in),
            .in_valid  (in_valid),
            .normal    (hit.normal),
            .light     (lights[i]),
            .mat       (mat_d),
            .out_valid (term_valid[i]),
            .term      (terms[i])
        );
    end

    color_mix color_mix_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (&term_valid),
        .terms     (terms),
        .draw      (draw),
        .out_valid (pixel_valid),
        .pixel     (pixel)
    );

endmodule

`default_nettype wire

//--- tests/pixel_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_monitor (
    input  wire                  clk_in,
    input  wire                  rst_in,
    input  wire                  expect_valid,
    input  wire [127:0]          expect_name,
    input  wire shade_pkg::rgb_t expect_pixel,
    input  wire                  pixel_valid,
    input  wire shade_pkg::rgb_t pixel,
    output int                   mismatches,
    output int                   other_errors,
    output int                   pending
);

    import shade_pkg::*;

    logic [127:0] name_q [$];
    rgb_t exp_q [$];
    int issue_q [$];
    int cycle;

    logic [127:0] name_now;
    rgb_t exp_now;
    int issue_now;

    // expected pixels enter on the same edge the DUT takes the hit
    always @(posedge clk_in) begin
        if (rst_in) begin
            cycle = 0;
            name_q.delete();
            exp_q.delete();
            issue_q.delete();
            pending = 0;
        end else begin
            if (pixel_valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected pixel_valid with no hit in flight at cycle %0d", cycle);
                    other_errors++;
                end else begin
                    name_now = name_q.pop_front();
                    exp_now = exp_q.pop_front();
                    issue_now = issue_q.pop_front();
                    if (cycle - issue_now != PIXEL_LATENCY) begin
                        $display("pixel for %0s came out after %0d cycles instead of %0d",
                                 name_now, cycle - issue_now, PIXEL_LATENCY);
                        other_errors++;
                    end
                    if (pixel !== exp_now) begin
                        $display("ERR %0s expected %h %h %h actual %h %h %h", name_now,
                                 exp_now.r, exp_now.g, exp_now.b,
                                 pixel.r, pixel.g, pixel.b);
                        mismatches++;
                    end
                end
            end
            // oldest hit overdue
            if (issue_q.size() > 0 && cycle - issue_q[0] >= PIXEL_LATENCY) begin
                $display("no pixel output for %0s", name_q[0]);
                other_errors++;
                name_now = name_q.pop_front();
                exp_now = exp_q.pop_front();
                issue_now = issue_q.pop_front();
            end
            if (expect_valid) begin
                name_q.push_back(expect_name);
                exp_q.push_back(expect_pixel);
                issue_q.push_back(cycle);
            end
            pending = exp_q.size();
            cycle++;
        end
    end

endmodule

`default_nettype wire

//--- tests/pixel_shader_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shader_properties (
    input wire                     clk_in,
    input wire                     rst_in,
    input wire shade_pkg::wb_req_t wb_req,
    input wire shade_pkg::wb_rsp_t wb_rsp,
    input wire                     in_valid,
    input wire                     pixel_valid
);

    import shade_pkg::*;

    int failures;

    ack_in_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            $error("ack outside a bus cycle");
            failures++;
        end

    ack_single: assert property (@(posedge clk_in) disable iff (rst_in)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack high two cycles in a row");
            failures++;
        end

    // fixed pipeline depth, no stalls
    pixel_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        pixel_valid == $past(in_valid, PIXEL_LATENCY))
        else begin
            $error("pixel_valid does not follow in_valid by the pipeline depth");
            failures++;
        end

endmodule

bind pixel_shader pixel_shader_properties pixel_shader_properties_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .in_valid    (in_valid),
    .pixel_valid (pixel_valid)
);

`default_nettype wire

//--- tests/tb_pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_shader;

    import shade_pkg::*;

    logic clk_in;
    logic rst_in;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic in_valid;
    hit_t hit;
    logic pixel_valid;
    rgb_t pixel;

    logic expect_valid;
    logic [127:0] expect_name;
    rgb_t expect_pixel;
    int mismatches;
    int other_errors;
    int pending;

    int read_errors;
    int tb_errors;
    int assert_errors;
    int cycle;
    int limit;
    string lines [$];

    pixel_shader pixel_shader_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .in_valid    (in_valid),
        .hit         (hit),
        .pixel_valid (pixel_valid),
        .pixel       (pixel)
    );

    pixel_monitor pixel_monitor_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .expect_valid (expect_valid),
        .expect_name  (expect_name),
        .expect_pixel (expect_pixel),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .pending      (pending)
    );

    always #2 clk_in = ~clk_in;

    //////////////////////////////////////////////////////////////////////
    // watchdog
    always @(posedge clk_in) begin
        cycle++;
        if (limit > 0 && cycle >= limit) begin
            $display("run stopped by timeout after %0d cycles", cycle);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic read_cases();
        int fd;
        string line;
        fd = $fopen("tests/shade_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/shade_cases.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // one classic cycle, returns after stb is dropped
    task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat);
        int n;
        logic got;
        n = 0;
        got = 1'b0;
        rdat = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!got && n < 10) begin
            @(posedge clk_in);
            n++;
            if (wb_rsp.ack) begin
                got = 1'b1;
                rdat = wb_rsp.dat;
            end
        end
        #1 wb_req = '0;
        if (!got) begin
            $display("no ack for bus access to address %0d", adr);
            tb_errors++;
        end else begin
            @(posedge clk_in);
            if (wb_rsp.ack) begin
                $display("ack held for more than one cycle at address %0d", adr);
                tb_errors++;
            end
            #1;
        end
    endtask

    task automatic idle_inputs();
        in_valid = 1'b0;
        expect_valid = 1'b0;
        hit = '0;
    endtask

    task automatic run_cases();
        logic [127:0] kind;
        logic [127:0] name;
        logic [31:0] v [17];
        logic [31:0] rdat;
        logic in_flight;
        int cnt;
        in_flight = 1'b0;
        foreach (lines[i]) begin
            cnt = $sscanf(lines[i], "%s", kind);
            if (kind == "P") begin
                cnt = $sscanf(lines[i], "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              kind, name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                              v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
                if (cnt != 19) begin
                    $display("case line has %0d fields instead of 19: %s", cnt, lines[i]);
                    tb_errors++;
                end
                hit.ray = '{x: v[0], y: v[1], z: v[2]};
                hit.t = v[3];
                hit.block.pos = '{x: v[4], y: v[5], z: v[6]};
                hit.block.dir = dir_t'(v[7][1:0]);
                hit.mat = '{r: v[8], g: v[9], b: v[10]};
                hit.normal = '{x: v[11], y: v[12], z: v[13]};
                in_valid = 1'b1;
                expect_valid = 1'b1;
                expect_name = name;
                expect_pixel = '{r: v[14], g: v[15], b: v[16]};
                in_flight = 1'b1;
                @(posedge clk_in);
                #1;
            end else begin
                idle_inputs();
                // registers stay put while hits are in the pipeline
                if (in_flight) begin
                    repeat (PIXEL_LATENCY + 1) @(posedge clk_in);
                    #1;
                    in_flight = 1'b0;
                end
                cnt = $sscanf(lines[i], "%s %h %h", kind, v[0], v[1]);
                if ((kind == "W" || kind == "R") && cnt != 3) begin
                    $display("case line has %0d fields instead of 3: %s", cnt, lines[i]);
                    tb_errors++;
                end
                if (kind == "W") begin
                    wb_access(1'b1, v[0][4:0], v[1], rdat);
                end else if (kind == "R") begin
                    wb_access(1'b0, v[0][4:0], '0, rdat);
                    if (rdat !== v[1]) begin
                        $display("ERR read_%0d expected %h actual %h", v[0], v[1], rdat);
                        read_errors++;
                    end
                end else begin
                    $display("unknown line in case file: %s", lines[i]);
                    tb_errors++;
                end
            end
        end
        idle_inputs();
    endtask

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;
        wb_req = '0;
        in_valid = 1'b0;
        hit = '0;
        expect_valid = 1'b0;
        expect_name = '0;
        expect_pixel = '0;
        read_errors = 0;
        tb_errors = 0;
        assert_errors = 0;
        cycle = 0;
        limit = 0;
        read_cases();
        limit = lines.size() * 4 + PIXEL_LATENCY + 50;

        repeat (8) @(posedge clk_in);
        #1 rst_in = 1'b0;

        // quiet bus after reset
        repeat (3) begin
            @(posedge clk_in);
            if (wb_rsp.ack) begin
                $display("ack high with no request after reset");
                tb_errors++;
            end
        end
        #1;

        run_cases();
        @(posedge clk_in);
        while (pending != 0) begin
            @(posedge clk_in);
        end
        repeat (2) @(posedge clk_in);

        assert_errors = pixel_shader_i.pixel_shader_properties_i.failures;
        $display("errors: readback %0d, pixel %0d, assertion %0d, other %0d", read_errors,
                 mismatches, assert_errors, other_errors + tb_errors);
        if (read_errors + mismatches + assert_errors + other_errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/shade_cases.txt
# W adr data | R adr expected | P name ray.xyz t pos.xyz dir mat.rgb normal.xyz expected.rgb
# all values hex Q16.16, dir 0 up 1 right 2 down 3 left
P zero_lights 00000000 00000000 FFFF0000 00640000 00000000 00000000 00000000 0 00008000 00004000 0000C000 00000000 00000000 00010000 00000000 00000000 00000000
W 02 012C0000
W 05 00010000
W 06 00010000
W 07 00010000
W 08 00010000
W 0B FFFF0000
W 0C 00010000
W 0D 00010000
W 0E 00010000
W 0F 00010000
W 12 00008000
W 13 00008000
W 14 00008000
R 02 012C0000
R 05 00010000
R 0B FFFF0000
R 0F 00010000
R 14 00008000
R 1F 00000000
P plain 00000000 00000000 FFFF0000 00640000 03E80000 00000000 00000000 0 00008000 00004000 0000C000 00000000 00000000 00010000 00008000 00004000 0000C000
P tilted 00000000 00000000 FFFF0000 00640000 03E80000 00000000 00000000 0 00008000 00004000 0000C000 00008000 00000000 00008000 00006000 00003000 00009000
P arrow_up 00000000 00000000 FFFF0000 00640000 FFF60000 001E0000 00000000 0 00008000 00004000 0000C000 00000000 00000000 00010000 0000C000 0000C000 0000C000
P arrow_right 00000000 00000000 FFFF0000 00640000 FFE20000 FFF60000 00000000 1 00008000 00004000 0000C000 00000000 00000000 00010000 0000C000 0000C000 0000C000
P arrow_down 00000000 00000000 FFFF0000 00640000 FFF60000 FFE20000 00000000 2 00008000 00004000 0000C000 00000000 00000000 00010000 0000C000 0000C000 0000C000
P arrow_left 00000000 00000000 FFFF0000 00640000 001E0000 FFF60000 00000000 3 00008000 00004000 0000C000 00000000 00000000 00010000 0000C000 0000C000 0000C000
P wrong_dir 00000000 00000000 FFFF0000 00640000 FFF60000 001E0000 00000000 2 00008000 00004000 0000C000 00000000 00000000 00010000 00008000 00004000 0000C000
P out_of_bounds 00000000 00000000 FFFF0000 00640000 FFAB0000 001E0000 00000000 1 00008000 00004000 0000C000 00000000 00000000 00010000 00008000 00004000 0000C000
P off_top_face 00000000 00000000 FFFF0000 00640000 FFE20000 FFF60000 FFF60000 1 00008000 00004000 0000C000 00000000 00000000 00010000 00008000 00004000 0000C000

//--- list.f
rtl/shade_pkg.sv
rtl/delay_line.sv
rtl/shading_regs.sv
rtl/hit_point.sv
rtl/arrow_test.sv
rtl/light_term.sv
rtl/color_mix.sv
rtl/pixel_shader.sv
tests/pixel_monitor.sv
tests/pixel_shader_properties.sv
tests/tb_pixel_shader.sv

//--- run.sh
#!/bin/sh
# build and run the pixel shader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f list.f --top-module tb_pixel_shader -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
